// ==== dv/lz77_testdata.txt ====
// hex words per block: length, data bytes, then tokens until they cover the block
// token 00bb is literal byte bb, token LLDD a match of length LL at distance DD; 0000 ends
// distinct bytes, literals only
000a
01 02 03 04 05 06 07 08 09 0a
0001 0002 0003 0004 0005 0006 0007 0008 0009 000a
// repeat at distance 8 capped at max length, then a minimum length match
0013
10 11 12 13 14 15 16 17 10 11 12 13 14 15 16 17
10 11 12
0010 0011 0012 0013 0014 0015 0016 0017
0808 0308
// two byte repeat stays literal
0008
20 21 22 20 21 23 24 25
0020 0021 0022 0020 0021 0023 0024 0025
// length limited by distance, tie between distances 4 and 8
000d
61 62 63 64 61 62 63 64 61 62 63 64 65
0061 0062 0063 0064 0404 0404 0065
// same bytes as the previous block, no reach into it
0005
61 62 63 64 65
0061 0062 0063 0064 0065
// match at the deepest window distance
0024
80 81 82 83 84 85 86 87 88 89 8a 8b 8c 8d 8e 8f
90 91 92 93 94 95 96 97 98 99 9a 9b 9c 9d 9e 9f
80 81 82 83
0080 0081 0082 0083 0084 0085 0086 0087
0088 0089 008a 008b 008c 008d 008e 008f
0090 0091 0092 0093 0094 0095 0096 0097
0098 0099 009a 009b 009c 009d 009e 009f
0420
// repeat one byte beyond the window, literals only
0024
80 81 82 83 84 85 86 87 88 89 8a 8b 8c 8d 8e 8f
90 91 92 93 94 95 96 97 98 99 9a 9b 9c 9d 9e 9f
a0 80 81 82
0080 0081 0082 0083 0084 0085 0086 0087
0088 0089 008a 008b 008c 008d 008e 008f
0090 0091 0092 0093 0094 0095 0096 0097
0098 0099 009a 009b 009c 009d 009e 009f
00a0 0080 0081 0082
0000

// ==== dv/tb_clock_gen.sv ====
/*
  testbench clock and reset
  40 ns clock, active low reset held for the first 10 cycles
*/
module tb_clock_gen (
  output logic clk_o,
  output logic rstn_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int HALF_PERIOD = 20;
  localparam int RST_CYCLES  = 10;

  initial begin
    clk_o  = 1'b0;
    rstn_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    // release on a falling edge, away from the capturing edge
    @(negedge clk_o);
    rstn_o = 1'b1;
  end

  always #HALF_PERIOD clk_o = ~clk_o;

endmodule

// ==== dv/tb_lz77_top.sv ====
/*
  testbench for the lz77 compressor core
  blocks and expected tokens come from the test data file
  models the byte sender and the token sink with their credits
  checks tokens, last flag, done pulses and credit counts
*/
module tb_lz77_top
  import lz_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MEM_DEPTH = 512;
  localparam int SETTLE    = MAX_LEN + 2;
  localparam int MAX_DELAY = 7;

  logic      clk;
  logic      rstn;
  logic      start;
  blen_t     blk_len;
  logic      in_valid;
  byte_t     in_byte;
  logic      tok_credit;
  logic      in_credit;
  logic      tok_valid;
  lz_token_t tok;
  logic      done;

  logic [15:0] mem [MEM_DEPTH];
  byte_t       blk_bytes[$];
  lz_token_t   exp_q[$];
  int          due_q[$];
  int          seed = 37307;
  int          err_cnt;
  int          cyc;
  int          limit_cycles;
  int          blk_len_cur;
  int          snd_idx;
  int          snd_cred;
  int          sent;
  int          returned;
  int          granted;
  int          tok_cnt;
  int          done_cnt;
  logic        start_pend;
  logic        blk_done;
  logic        sending;
  logic        last_prev;

  tb_clock_gen i_clock_gen (
    .clk_o  (clk),
    .rstn_o (rstn)
  );

  lz77_top i_lz77_top (
    .clk          (clk),
    .rstn         (rstn),
    .start_i      (start),
    .blk_len_i    (blk_len),
    .in_valid_i   (in_valid),
    .in_byte_i    (in_byte),
    .tok_credit_i (tok_credit),
    .in_credit_o  (in_credit),
    .tok_valid_o  (tok_valid),
    .tok_o        (tok),
    .done_o       (done)
  );

  task automatic report_value(string name, int got, int exp);
    err_cnt++;
    $display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, got, exp);
  endtask

  // 00bb is a literal byte, LLDD a match of length LL at distance DD
  function automatic lz_token_t make_token(logic [15:0] w, logic last);
    lz_token_t t;
    t = '0;
    if (w[15:8] == 8'h00) begin
      t.is_lit = 1'b1;
      t.lit    = w[7:0];
      t.len    = len_t'(1);
    end else begin
      t.len = len_t'(w[15:8]);
      t.dst = dst_t'(w[7:0]);
    end
    t.last = last;
    return t;
  endfunction

  // length word, data bytes, then tokens until their lengths cover the block
  task automatic load_block(inout int p);
    logic [15:0] w;
    int          covered;
    int          tlen;
    blk_bytes.delete();
    exp_q.delete();
    blk_len_cur = int'(mem[p]);
    p++;
    for (int i = 0; i < blk_len_cur && p < MEM_DEPTH; i++) begin
      blk_bytes.push_back(mem[p][7:0]);
      p++;
    end
    covered = 0;
    while (covered < blk_len_cur && p < MEM_DEPTH) begin
      w = mem[p];
      p++;
      tlen = (w[15:8] == 8'h00) ? 1 : int'(w[15:8]);
      covered += tlen;
      exp_q.push_back(make_token(w, covered == blk_len_cur));
    end
    if (covered != blk_len_cur) begin
      err_cnt++;
      $display("token lengths in the data file do not add up to block length %0d", blk_len_cur);
    end
  endtask

  // --------------------
  // one clock cycle, sample on the falling edge then drive
  task automatic tick();
    lz_token_t exp_tok;
    int        due;
    @(negedge clk);
    cyc++;
    if (in_credit) begin
      returned++;
      snd_cred++;
      if (returned > sent) begin
        err_cnt++;
        $display("in_credit_o returned a credit for a byte never sent at %0t", $time);
      end
    end
    if (tok_valid) begin
      tok_cnt++;
      if (tok_cnt > OUT_CREDITS + granted) begin
        err_cnt++;
        $display("tok_valid_o fired with no output credit left at %0t", $time);
      end
      // sink frees the slot after a random delay, in token order
      due = cyc + 1 + ($random(seed) & MAX_DELAY);
      if (due_q.size() != 0 && due < due_q[$]) due = due_q[$];
      due_q.push_back(due);
      if (exp_q.size() == 0) begin
        err_cnt++;
        $display("token from the DUT at %0t with no token expected", $time);
      end else begin
        exp_tok = exp_q.pop_front();
        if (tok.is_lit != exp_tok.is_lit)
          report_value("tok_o.is_lit", int'(tok.is_lit), int'(exp_tok.is_lit));
        if (exp_tok.is_lit && tok.lit != exp_tok.lit)
          report_value("tok_o.lit", int'(tok.lit), int'(exp_tok.lit));
        if (tok.len != exp_tok.len)
          report_value("tok_o.len", int'(tok.len), int'(exp_tok.len));
        if (tok.dst != exp_tok.dst)
          report_value("tok_o.dst", int'(tok.dst), int'(exp_tok.dst));
        if (tok.last != exp_tok.last)
          report_value("tok_o.last", int'(tok.last), int'(exp_tok.last));
      end
    end
    if (done) begin
      done_cnt++;
      blk_done = 1'b1;
      if (!last_prev) begin
        err_cnt++;
        $display("done_o pulsed at %0t without a last token in the cycle before", $time);
      end
    end
    last_prev  = tok_valid && tok.last;
    start      = start_pend;
    start_pend = 1'b0;
    tok_credit = 1'b0;
    if (due_q.size() != 0 && due_q[0] <= cyc) begin
      void'(due_q.pop_front());
      tok_credit = 1'b1;
      granted++;
    end
    in_valid = 1'b0;
    if (sending && snd_cred > 0 && snd_idx < blk_bytes.size()) begin
      in_valid = 1'b1;
      in_byte  = blk_bytes[snd_idx];
      snd_idx++;
      snd_cred--;
      sent++;
    end
  endtask

  task automatic run_block();
    int done_before;
    snd_idx     = 0;
    snd_cred    = MAX_LEN;
    sent        = 0;
    returned    = 0;
    blk_done    = 1'b0;
    done_before = done_cnt;
    blk_len     = blen_t'(blk_len_cur);
    start_pend  = 1'b1;
    sending     = 1'b1;
    while (!blk_done) tick();
    if (exp_q.size() != 0) begin
      err_cnt++;
      $display("block ended with %0d expected tokens never issued", exp_q.size());
    end
    // bytes of the last token still drain into the window after done
    repeat (SETTLE) tick();
    if (returned != blk_len_cur) report_value("in_credit_o pulses", returned, blk_len_cur);
    if (done_cnt - done_before != 1) report_value("done_o pulses", done_cnt - done_before, 1);
    sending = 1'b0;
  endtask

  // --------------------
  initial begin
    int p;
    int total;
    int n_blk;
    start      = 1'b0;
    blk_len    = '0;
    in_valid   = 1'b0;
    in_byte    = '0;
    tok_credit = 1'b0;
    start_pend = 1'b0;
    sending    = 1'b0;
    blk_done   = 1'b0;
    last_prev  = 1'b0;
    err_cnt    = 0;
    cyc        = 0;
    granted    = 0;
    tok_cnt    = 0;
    done_cnt   = 0;
    $readmemh("dv/lz77_testdata.txt", mem);

    // first pass sizes the watchdog
    p     = 0;
    total = 0;
    n_blk = 0;
    while (p < MEM_DEPTH && mem[p] != 16'h0000) begin
      load_block(p);
      total += blk_len_cur;
      n_blk++;
    end
    if (n_blk == 0) begin
      err_cnt++;
      $display("no blocks found in the data file");
    end
    limit_cycles = total * (MAX_LEN + 4) + n_blk * (SETTLE + 20) + 60;

    wait (rstn);
    repeat (8) begin
      tick();
      if (tok_valid !== 1'b0) report_value("tok_valid_o", int'(tok_valid), 0);
      if (in_credit !== 1'b0) report_value("in_credit_o", int'(in_credit), 0);
      if (done !== 1'b0) report_value("done_o", int'(done), 0);
    end

    p     = 0;
    n_blk = 0;
    while (p < MEM_DEPTH && mem[p] != 16'h0000) begin
      load_block(p);
      run_block();
      n_blk++;
    end

    $display("lz77 test: %0d blocks, %0d tokens, %0d errors", n_blk, tok_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("timeout: run did not complete within %0d cycles", limit_cycles);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== list.f ====
src/lz_pkg.sv
src/lz_input_buffer.sv
src/lz_history_window.sv
src/lz_match_search.sv
src/lz_compress_ctrl.sv
src/lz77_top.sv
dv/tb_clock_gen.sv
dv/tb_lz77_top.sv

// ==== run.sh ====
#!/bin/sh
# compile the lz77 core and its testbench with verilator, then run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_lz77_top -f list.f || exit 1
out=$(./obj_dir/Vtb_lz77_top)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'Simulation finished: PASS' && exit 0 || exit 1

// ==== src/lz77_top.sv ====
/*
  lz77 compressor core top level
  control, lookahead buffer, history window and match search
  credit based byte input and token output
*/
module lz77_top
  import lz_pkg::*;
(
  input  logic      clk,
  input  logic      rstn,
  input  logic      start_i,
  input  blen_t     blk_len_i,
  input  logic      in_valid_i,
  input  byte_t     in_byte_i,
  input  logic      tok_credit_i,
  output logic      in_credit_o,
  output logic      tok_valid_o,
  output lz_token_t tok_o,
  output logic      done_o
);

  byte_t [MAX_LEN-1:0]  look;
  byte_t [WIN_SIZE-1:0] win;
  fill_t                buf_fill;
  fill_t                win_fill;
  logic                 shift_valid;
  byte_t                shift_byte;
  logic                 clear;
  logic                 init;
  logic                 step;
  len_t                 step_idx;
  len_t                 avail;
  logic                 consume;
  len_t                 consume_n;
  best_t                best;
  logic                 flags_empty;

  // --------------------
  lz_compress_ctrl i_ctrl (
    .clk           (clk),
    .rstn          (rstn),
    .start_i       (start_i),
    .blk_len_i     (blk_len_i),
    .buf_fill_i    (buf_fill),
    .best_i        (best),
    .flags_empty_i (flags_empty),
    .look_first_i  (look[0]),
    .tok_credit_i  (tok_credit_i),
    .clear_o       (clear),
    .init_o        (init),
    .step_o        (step),
    .step_idx_o    (step_idx),
    .avail_o       (avail),
    .consume_o     (consume),
    .consume_n_o   (consume_n),
    .tok_valid_o   (tok_valid_o),
    .tok_o         (tok_o),
    .done_o        (done_o)
  );

  lz_input_buffer i_input_buffer (
    .clk           (clk),
    .rstn          (rstn),
    .clear_i       (clear),
    .in_valid_i    (in_valid_i),
    .in_byte_i     (in_byte_i),
    .consume_n_i   (consume_n),
    .consume_i     (consume),
    .in_credit_o   (in_credit_o),
    .look_o        (look),
    .fill_o        (buf_fill),
    .shift_valid_o (shift_valid),
    .shift_byte_o  (shift_byte)
  );

  // consumed bytes move straight into the window
  lz_history_window i_history_window (
    .clk           (clk),
    .rstn          (rstn),
    .clear_i       (clear),
    .shift_valid_i (shift_valid),
    .shift_byte_i  (shift_byte),
    .win_o         (win),
    .win_fill_o    (win_fill)
  );

  lz_match_search i_match_search (
    .clk           (clk),
    .rstn          (rstn),
    .init_i        (init),
    .step_i        (step),
    .step_idx_i    (step_idx),
    .look_i        (look),
    .win_i         (win),
    .win_fill_i    (win_fill),
    .avail_i       (avail),
    .best_o        (best),
    .flags_empty_o (flags_empty)
  );

endmodule

// ==== src/lz_compress_ctrl.sv ====
/*
  block control for the lz77 core
  IDLE / UPDATE / SEARCH state machine, remaining byte and step counts
  literal or match decision, token issue under output credits
  last flag and done pulse
*/
module lz_compress_ctrl
  import lz_pkg::*;
(
  input  logic      clk,
  input  logic      rstn,
  input  logic      start_i,
  input  blen_t     blk_len_i,
  input  fill_t     buf_fill_i,
  input  best_t     best_i,
  input  logic      flags_empty_i,
  input  byte_t     look_first_i,
  input  logic      tok_credit_i,
  output logic      clear_o,
  output logic      init_o,
  output logic      step_o,
  output len_t      step_idx_o,
  output len_t      avail_o,
  output logic      consume_o,
  output len_t      consume_n_o,
  output logic      tok_valid_o,
  output lz_token_t tok_o,
  output logic      done_o
);

  lz_state_e          state_q;
  lz_state_e          state_nxt;
  blen_t              rem_q;
  len_t               step_q;
  len_t               wait_q;
  logic               first_q;
  logic [OCRED_W-1:0] ocred_q;
  logic               done_q;
  len_t               avail;
  logic               drained;
  logic               srch_done;
  logic               use_match;
  len_t               tok_len;
  logic               is_last;
  logic               issue;

  // --------------------
  // search window and progress
  assign avail   = (rem_q >= blen_t'(MAX_LEN)) ? len_t'(MAX_LEN) : len_t'(rem_q);
  // wait_q covers the drain into the window after each token
  assign drained = (wait_q == '0);

  // window is cleared only once the previous block has fully drained
  assign clear_o = (state_q == UPDATE) && first_q && drained;
  assign init_o  = (state_q == UPDATE) && !first_q && drained &&
                   (buf_fill_i >= fill_t'(avail));

  // early end once no candidate survives
  assign srch_done  = flags_empty_i || (step_q == avail);
  assign step_o     = (state_q == SEARCH) && !srch_done;
  assign step_idx_o = step_q;
  assign avail_o    = avail;

  // --------------------
  // token forming
  assign use_match = best_i.found && (best_i.len >= len_t'(MIN_LEN));
  assign tok_len   = use_match ? best_i.len : len_t'(1);
  assign is_last   = (rem_q == blen_t'(tok_len));
  // finished token waits here while the sink has no free slot
  assign issue     = (state_q == SEARCH) && srch_done && (ocred_q != '0);

  always_comb begin
    tok_o.is_lit = !use_match;
    tok_o.lit    = look_first_i;
    tok_o.len    = tok_len;
    tok_o.dst    = use_match ? best_i.dst : dst_t'(0);
    tok_o.last   = is_last;
  end

  assign tok_valid_o = issue;
  assign consume_o   = issue;
  assign consume_n_o = tok_len;
  assign done_o      = done_q;

  // --------------------
  // state machine
  always_comb begin
    state_nxt = state_q;
    case (state_q)
      IDLE:    if (start_i && (blk_len_i != '0)) state_nxt = UPDATE;
      UPDATE:  if (init_o) state_nxt = SEARCH;
      SEARCH:  if (issue) state_nxt = is_last ? IDLE : UPDATE;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q <= IDLE;
      rem_q   <= '0;
      step_q  <= '0;
      wait_q  <= '0;
      first_q <= 1'b0;
      ocred_q <= OCRED_W'(OUT_CREDITS);
      done_q  <= 1'b0;
    end else begin
      state_q <= state_nxt;
      done_q  <= issue && is_last;
      ocred_q <= ocred_q - OCRED_W'(issue) + OCRED_W'(tok_credit_i);

      if ((state_q == IDLE) && start_i && (blk_len_i != '0)) begin
        rem_q   <= blk_len_i;
        first_q <= 1'b1;
      end else if (issue) begin
        rem_q <= rem_q - blen_t'(tok_len);
      end
      if (clear_o) begin
        first_q <= 1'b0;
      end

      if (init_o) begin
        step_q <= '0;
      end else if (step_o) begin
        step_q <= step_q + 1'b1;
      end

      if (issue) begin
        wait_q <= tok_len;
      end else if (!drained) begin
        wait_q <= wait_q - 1'b1;
      end
    end
  end

endmodule

// ==== src/lz_history_window.sv ====
/*
  sliding history window
  shift register of recent bytes, entry 0 is distance 1
  fill count saturating at the window depth
*/
module lz_history_window
  import lz_pkg::*;
(
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 clear_i,
  input  logic                 shift_valid_i,
  input  byte_t                shift_byte_i,
  output byte_t [WIN_SIZE-1:0] win_o,
  output fill_t                win_fill_o
);

  byte_t [WIN_SIZE-1:0] win_q;
  fill_t                fill_q;

  assign win_o      = win_q;
  assign win_fill_o = fill_q;

  // newest byte enters at distance 1, oldest falls off the end
  always_ff @(posedge clk) begin
    if (shift_valid_i) begin
      win_q <= {win_q[WIN_SIZE-2:0], shift_byte_i};
    end
  end

  // fill count restarts at each block start
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      fill_q <= '0;
    end else if (clear_i) begin
      fill_q <= '0;
    end else if (shift_valid_i && (fill_q != fill_t'(WIN_SIZE))) begin
      fill_q <= fill_q + 1'b1;
    end
  end

endmodule

// ==== src/lz_input_buffer.sv ====
/*
  lookahead byte buffer
  stores credited input bytes in arrival order, entry 0 oldest
  drains a requested byte count toward the history window,
  one byte and one credit pulse per cycle
*/
module lz_input_buffer
  import lz_pkg::*;
(
  input  logic                clk,
  input  logic                rstn,
  input  logic                clear_i,
  input  logic                in_valid_i,
  input  byte_t               in_byte_i,
  input  len_t                consume_n_i,
  input  logic                consume_i,
  output logic                in_credit_o,
  output byte_t [MAX_LEN-1:0] look_o,
  output fill_t               fill_o,
  output logic                shift_valid_o,
  output byte_t               shift_byte_o
);

  byte_t [MAX_LEN-1:0] buf_q;
  fill_t               fill_q;
  len_t                drain_q;
  logic                shift;
  fill_t               wr_idx;

  // one byte leaves per cycle while a drain is pending
  assign shift         = (drain_q != '0);
  assign shift_valid_o = shift;
  assign shift_byte_o  = buf_q[0];
  assign in_credit_o   = shift;
  assign look_o        = buf_q;
  assign fill_o        = fill_q;

  // new byte lands behind the current tail, one slot lower when shifting
  assign wr_idx = shift ? fill_q - 1'b1 : fill_q;

  always_ff @(posedge clk) begin
    if (shift) begin
      for (int i = 0; i < MAX_LEN - 1; i++) begin
        buf_q[i] <= buf_q[i+1];
      end
    end
    if (in_valid_i) begin
      buf_q[wr_idx] <= in_byte_i;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      fill_q  <= '0;
      drain_q <= '0;
    end else begin
      fill_q <= fill_q + fill_t'(in_valid_i) - fill_t'(shift);
      // abandon any drain still pending at block start
      if (clear_i) begin
        drain_q <= '0;
      end else if (consume_i) begin
        drain_q <= consume_n_i;
      end else if (shift) begin
        drain_q <= drain_q - 1'b1;
      end
    end
  end

endmodule

// ==== src/lz_match_search.sv ====
/*
  match search over the history window
  one flag per candidate distance, cleared byte by byte
  nearest surviving distance picked after each step
  best match register holding found, length and distance
*/
module lz_match_search
  import lz_pkg::*;
(
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 init_i,
  input  logic                 step_i,
  input  len_t                 step_idx_i,
  input  byte_t [MAX_LEN-1:0]  look_i,
  input  byte_t [WIN_SIZE-1:0] win_i,
  input  fill_t                win_fill_i,
  input  len_t                 avail_i,
  output best_t                best_o,
  output logic                 flags_empty_o
);

  logic [WIN_SIZE-1:0] flags_q;
  logic [WIN_SIZE-1:0] flags_nxt;
  best_t               best_q;
  logic                any_hit;
  dst_t                near_dst;

  // --------------------
  // flag update
  // candidate d compares window byte at distance d - idx with lookahead byte idx;
  // d not above idx would reach into the lookahead, d above fill has no history
  always_comb begin
    flags_nxt = '0;
    for (int d = 1; d <= WIN_SIZE; d++) begin
      if ((d > step_idx_i) && (d <= win_fill_i)) begin
        flags_nxt[d-1] = flags_q[d-1] &&
                         (win_i[d - 1 - step_idx_i] == look_i[step_idx_i]);
      end
    end
  end

  // --------------------
  // nearest distance wins
  always_comb begin
    near_dst = '0;
    any_hit  = 1'b0;
    for (int d = WIN_SIZE; d >= 1; d--) begin
      if (flags_nxt[d-1]) begin
        near_dst = dst_t'(d);
        any_hit  = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      flags_q <= '0;
      best_q  <= '0;
    end else if (init_i) begin
      flags_q <= '1;
      best_q  <= '0;
    end else if (step_i) begin
      flags_q <= flags_nxt;
      // a survivor after step idx means idx + 1 bytes matched
      if (any_hit && (step_idx_i < avail_i)) begin
        best_q.found <= 1'b1;
        best_q.len   <= step_idx_i + 1'b1;
        best_q.dst   <= near_dst;
      end
    end
  end

  assign best_o        = best_q;
  assign flags_empty_o = ~|flags_q;

endmodule

// ==== src/lz_pkg.sv ====
/*
  shared sizes for the lz77 compressor core
  byte, length, distance, block length and fill types
  token and best match structs, block state enum
*/
package lz_pkg;

  // --------------------
  // sizes
  localparam int WIN_SIZE    = 32;
  localparam int MAX_LEN     = 8;
  localparam int MIN_LEN     = 3;
  localparam int OUT_CREDITS = 2;

  localparam int LEN_W   = $clog2(MAX_LEN + 1);
  localparam int DST_W   = $clog2(WIN_SIZE + 1);
  localparam int FILL_W  = $clog2(WIN_SIZE + 1);
  localparam int BLEN_W  = 12;
  localparam int OCRED_W = $clog2(OUT_CREDITS + 1);

  // --------------------
  // types
  typedef logic [7:0]        byte_t;
  typedef logic [LEN_W-1:0]  len_t;
  typedef logic [DST_W-1:0]  dst_t;
  typedef logic [BLEN_W-1:0] blen_t;
  typedef logic [FILL_W-1:0] fill_t;

  // literal tokens carry len 1 and dst 0
  typedef struct packed {
    logic  is_lit;
    byte_t lit;
    len_t  len;
    dst_t  dst;
    logic  last;
  } lz_token_t;

  typedef struct packed {
    logic found;
    len_t len;
    dst_t dst;
  } best_t;

  typedef enum logic [1:0] {IDLE, UPDATE, SEARCH} lz_state_e;

endpackage
